// File: filelist.f
logic/rv_pipe_pkg.sv
logic/fetch_handshake.sv
logic/decode_stage.sv
logic/reg_file.sv
logic/execute_stage.sv
logic/rv_pipe_top.sv
test/rv_pipe_props.sv
test/rv_pipe_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = rv_pipe_tb
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
RUN_ARGS  = +verilator+error+limit+100

.PHONY: sim clean

# the run passes only if the pass line shows up in the simulator output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf $(OBJ_DIR)

// File: test/rv_pipe_patterns.txt
# columns: instruction word (hex), expected rd (decimal), expected data (hex)
# rd 0 means the instruction must be acknowledged without a writeback
800000B7 1 80000000
12308093 1 80000123
00500113 2 00000005
FF000193 3 FFFFFFF0
00208233 4 80000128
403102B3 5 00000015
00211333 6 000000A0
0020A3B3 7 00000001
0020B433 8 00000000
0030C4B3 9 7FFFFED3
0020D533 10 04000009
4020D5B3 11 FC000009
00316633 12 FFFFFFF5
0030F6B3 13 80000120
F9C10713 14 FFFFFFA1
FFF13793 15 00000001
FF11A813 16 00000001
7FF1C893 17 FFFFF80F
01C11913 18 50000000
4021D993 19 FFFFFFFC
01C9DA13 20 0000000F
100A6A93 21 0000010F
1F0AFB13 22 00000100
00710013 0 00000000
0020A423 0 00000000
00200BB3 23 00000005

// File: test/rv_pipe_tb.sv
`timescale 1ns/1ps

module rv_pipe_tb;
  import rv_pipe_pkg::*;

  localparam int CLK_PERIOD  = 100;
  localparam int DRIVE_DELAY = 10;
  localparam int ACK_TIMEOUT = 20;
  // writeback register loads two edges after the acceptance edge
  localparam int WB_EDGES    = 2;
  localparam int QUIET_EDGES = 5;

  typedef struct packed {
    logic [XLEN-1:0]       word;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       data;
  } pattern_t;

  typedef struct packed {
    logic [31:0]           due;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       data;
  } expect_t;

  logic                  clk;
  logic                  rst_i;
  logic                  inst_req_i;
  logic [XLEN-1:0]       inst_i;
  logic                  inst_ack_o;
  logic                  wb_valid_o;
  logic [REG_ADDR_W-1:0] wb_rd_o;
  logic [XLEN-1:0]       wb_data_o;

  logic [31:0] edge_cnt;
  logic [31:0] lfsr;
  logic        watch_on;
  pattern_t    patterns[$];
  expect_t     pending[$];

  rv_pipe_top #(
    .REG_COUNT (32)
  ) rv_pipe_top_inst (
    .clk        (clk),
    .rst_i      (rst_i),
    .inst_req_i (inst_req_i),
    .inst_i     (inst_i),
    .inst_ack_o (inst_ack_o),
    .wb_valid_o (wb_valid_o),
    .wb_rd_o    (wb_rd_o),
    .wb_data_o  (wb_data_o)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  always @(posedge clk) begin
    edge_cnt <= edge_cnt + 1;
  end

  // ==========================================================
  // helpers
  // ==========================================================

  task automatic stop_on_error(input string reason);
    $display("%s", reason);
    $display("Verification failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      stop_on_error($sformatf("mismatch at %0t ns: %s is %h, expected %h",
                              $time, name, actual, expected));
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  task automatic random_gap(output int gap);
    gap = 0;
    repeat (2) begin
      lfsr = lfsr_next(lfsr);
      gap  = (gap << 1) | int'(lfsr[0]);
    end
  endtask

  task automatic load_patterns();
    int                    fd;
    string                 line;
    logic [XLEN-1:0]       word;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       data;
    fd = $fopen("test/rv_pipe_patterns.txt", "r");
    if (fd == 0) begin
      stop_on_error("could not open test/rv_pipe_patterns.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        // skip column notes and blank lines
        if (line.len() > 1 && line[0] != "#") begin
          if ($sscanf(line, "%h %d %h", word, rd, data) == 3) begin
            patterns.push_back('{word: word, rd: rd, data: data});
          end else begin
            stop_on_error({"unreadable line in pattern file: ", line});
          end
        end
      end
      $fclose(fd);
      if (patterns.size() == 0) begin
        stop_on_error("pattern file holds no instructions");
      end
    end
  endtask

  task automatic wait_ack(input logic level);
    int cycles;
    cycles = 0;
    while (inst_ack_o !== level) begin
      if (cycles == ACK_TIMEOUT) begin
        stop_on_error($sformatf("timeout at %0t ns: ack never went to %0d",
                                $time, level));
      end else begin
        next_cycle();
        cycles++;
      end
    end
  endtask

  // ==========================================================
  // handshake driver and writeback monitor
  // ==========================================================

  task automatic send_instruction(input pattern_t pat);
    expect_t exp;
    check_value("inst_ack_o", 32'(inst_ack_o), 32'd0);
    inst_i     = pat.word;
    inst_req_i = 1'b1;
    wait_ack(1'b1);
    // edge_cnt now counts the acceptance edge
    if (pat.rd != '0) begin
      exp.due  = edge_cnt + WB_EDGES;
      exp.rd   = pat.rd;
      exp.data = pat.data;
      pending.push_back(exp);
    end
    inst_req_i = 1'b0;
    wait_ack(1'b0);
  endtask

  task automatic watch_writeback();
    expect_t exp;
    if (wb_valid_o) begin
      if (pending.size() == 0) begin
        stop_on_error($sformatf("unexpected writeback to x%0d at %0t ns", wb_rd_o, $time));
      end else begin
        exp = pending.pop_front();
        check_value("writeback edge", edge_cnt, exp.due);
        check_value("wb_rd_o", 32'(wb_rd_o), 32'(exp.rd));
        check_value("wb_data_o", wb_data_o, exp.data);
      end
    end else if (pending.size() != 0 && edge_cnt > pending[0].due) begin
      stop_on_error($sformatf("writeback to x%0d missing at %0t ns", pending[0].rd, $time));
    end
  endtask

  // sampled mid-cycle away from the driving edge
  always @(negedge clk) begin
    if (watch_on) begin
      watch_writeback();
    end
  end

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (pending.size() != 0) begin
      if (cycles == ACK_TIMEOUT) begin
        stop_on_error("timeout: expected writebacks never arrived");
      end else begin
        next_cycle();
        cycles++;
      end
    end
    // quiet window so the monitor can catch any stray pulse
    repeat (QUIET_EDGES) next_cycle();
  endtask

  // ==========================================================
  // main sequence
  // ==========================================================

  initial begin
    int gap;
    rst_i      = 1'b1;
    inst_req_i = 1'b0;
    inst_i     = '0;
    edge_cnt   = '0;
    lfsr       = 32'hac15_542a;
    watch_on   = 1'b0;
    load_patterns();
    repeat (3) @(posedge clk);
    #DRIVE_DELAY;
    rst_i = 1'b0;
    check_value("inst_ack_o", 32'(inst_ack_o), 32'd0);
    check_value("wb_valid_o", 32'(wb_valid_o), 32'd0);
    watch_on = 1'b1;
    // run 0 back to back for the bypass and run 1 with random idle gaps
    for (int run = 0; run < 2; run++) begin
      foreach (patterns[i]) begin
        if (run == 1) begin
          random_gap(gap);
          repeat (gap) next_cycle();
        end
        send_instruction(patterns[i]);
      end
    end
    wait_drain();
    if (rv_pipe_top_inst.rv_pipe_props_inst.failures == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: test/rv_pipe_props.sv
`timescale 1ns/1ps

module rv_pipe_props (
  input logic                               clk,
  input logic                               rst_i,
  input logic                               req_i,
  input logic                               ack_i,
  input logic                               wb_valid_i,
  input logic [rv_pipe_pkg::REG_ADDR_W-1:0] wb_rd_i
);

  int failures = 0;

  // ack only answers a pending request
  ack_needs_req: assert property (@(posedge clk) disable iff (rst_i)
    $rose(ack_i) |-> $past(req_i))
    else begin
      failures++;
      $error("ack rose without a request");
    end

  // writeback is a single-cycle pulse
  wb_single_pulse: assert property (@(posedge clk) disable iff (rst_i)
    wb_valid_i |=> !wb_valid_i)
    else begin
      failures++;
      $error("wb_valid_o held high for two cycles");
    end

  // x0 is never a writeback target
  wb_rd_nonzero: assert property (@(posedge clk) disable iff (rst_i)
    wb_valid_i |-> (wb_rd_i != '0))
    else begin
      failures++;
      $error("writeback to x0 flagged valid");
    end

endmodule

bind rv_pipe_top rv_pipe_props rv_pipe_props_inst (
  .clk        (clk),
  .rst_i      (rst_i),
  .req_i      (inst_req_i),
  .ack_i      (inst_ack_o),
  .wb_valid_i (wb_valid_o),
  .wb_rd_i    (wb_rd_o)
);

// File: logic/rv_pipe_top.sv
`timescale 1ns/1ps

module rv_pipe_top #(
  parameter int REG_COUNT = 32
) (
  input  logic                               clk,
  input  logic                               rst_i,
  input  logic                               inst_req_i,
  input  logic [rv_pipe_pkg::XLEN-1:0]       inst_i,
  output logic                               inst_ack_o,
  output logic                               wb_valid_o,
  output logic [rv_pipe_pkg::REG_ADDR_W-1:0] wb_rd_o,
  output logic [rv_pipe_pkg::XLEN-1:0]       wb_data_o
);
  import rv_pipe_pkg::*;

  inst_u                 inst_word;
  inst_u                 fetch_inst;
  logic                  fetch_valid;
  logic [REG_ADDR_W-1:0] rs1_addr;
  logic [REG_ADDR_W-1:0] rs2_addr;
  logic [XLEN-1:0]       rs1_data;
  logic [XLEN-1:0]       rs2_data;
  id_ex_t                id_ex;
  wb_t                   wb;

  assign inst_word = inst_i;

  fetch_handshake fetch_handshake_inst (
    .clk           (clk),
    .rst_i         (rst_i),
    .inst_req_i    (inst_req_i),
    .inst_i        (inst_word),
    .inst_ack_o    (inst_ack_o),
    .fetch_valid_o (fetch_valid),
    .fetch_inst_o  (fetch_inst)
  );

  decode_stage #(
    .REG_COUNT (REG_COUNT)
  ) decode_stage_inst (
    .clk           (clk),
    .rst_i         (rst_i),
    .fetch_valid_i (fetch_valid),
    .fetch_inst_i  (fetch_inst),
    .rs1_addr_o    (rs1_addr),
    .rs2_addr_o    (rs2_addr),
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    .id_ex_o       (id_ex)
  );

  // write port fed straight from the writeback register
  reg_file #(
    .REG_COUNT (REG_COUNT)
  ) reg_file_inst (
    .clk        (clk),
    .rst_i      (rst_i),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .wb_i       (wb)
  );

  execute_stage execute_stage_inst (
    .clk     (clk),
    .rst_i   (rst_i),
    .id_ex_i (id_ex),
    .wb_o    (wb)
  );

  assign wb_valid_o = wb.valid;
  assign wb_rd_o    = wb.rd;
  assign wb_data_o  = wb.data;

endmodule

// File: logic/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
  input  logic                clk,
  input  logic                rst_i,
  input  rv_pipe_pkg::id_ex_t id_ex_i,
  output rv_pipe_pkg::wb_t    wb_o
);
  import rv_pipe_pkg::*;

  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [4:0]      shamt;
  logic [XLEN-1:0] result;
  wb_t             wb_d;

  assign op_a  = id_ex_i.rs1_val;
  assign op_b  = id_ex_i.op2_val;
  // only the low five bits count for shifts
  assign shamt = op_b[4:0];

  // ==========================================================
  // ALU
  // ==========================================================

  always_comb begin
    case (id_ex_i.alu_op)
      ALU_ADD:    result = op_a + op_b;
      ALU_SUB:    result = op_a - op_b;
      ALU_SLL:    result = op_a << shamt;
      ALU_SLT:    result = XLEN'($signed(op_a) < $signed(op_b));
      ALU_SLTU:   result = XLEN'(op_a < op_b);
      ALU_XOR:    result = op_a ^ op_b;
      ALU_SRL:    result = op_a >> shamt;
      ALU_SRA:    result = $unsigned($signed(op_a) >>> shamt);
      ALU_OR:     result = op_a | op_b;
      ALU_AND:    result = op_a & op_b;
      ALU_PASS_B: result = op_b;
      default:    result = '0;
    endcase
  end

  // ==========================================================
  // writeback register
  // ==========================================================

  always_comb begin
    wb_d.valid = id_ex_i.valid;
    wb_d.rd    = id_ex_i.rd;
    wb_d.data  = result;
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      wb_o.valid <= 1'b0;
    end else begin
      wb_o <= wb_d;
    end
  end

endmodule

// File: logic/reg_file.sv
`timescale 1ns/1ps

module reg_file #(
  parameter int REG_COUNT = 32
) (
  input  logic                               clk,
  input  logic                               rst_i,
  input  logic [rv_pipe_pkg::REG_ADDR_W-1:0] rs1_addr_i,
  input  logic [rv_pipe_pkg::REG_ADDR_W-1:0] rs2_addr_i,
  output logic [rv_pipe_pkg::XLEN-1:0]       rs1_data_o,
  output logic [rv_pipe_pkg::XLEN-1:0]       rs2_data_o,
  input  rv_pipe_pkg::wb_t                   wb_i
);
  import rv_pipe_pkg::*;

  localparam int IDX_W = $clog2(REG_COUNT);

  logic [XLEN-1:0] regs [REG_COUNT];
  logic            wr_en;

  // x0 never takes a write
  assign wr_en = wb_i.valid & (wb_i.rd != '0);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wb_i.rd[IDX_W-1:0]] <= wb_i.data;
    end
  end

  // read with write-through of the pending writeback
  function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
    logic [XLEN-1:0] data;
    if (addr == '0) begin
      data = '0;
    end else if (wr_en && (wb_i.rd == addr)) begin
      data = wb_i.data;
    end else begin
      data = regs[addr[IDX_W-1:0]];
    end
    return data;
  endfunction

  assign rs1_data_o = read_port(rs1_addr_i);
  assign rs2_data_o = read_port(rs2_addr_i);

endmodule

// File: logic/decode_stage.sv
`timescale 1ns/1ps

module decode_stage #(
  parameter int REG_COUNT = 32
) (
  input  logic                               clk,
  input  logic                               rst_i,
  input  logic                               fetch_valid_i,
  input  rv_pipe_pkg::inst_u                 fetch_inst_i,
  output logic [rv_pipe_pkg::REG_ADDR_W-1:0] rs1_addr_o,
  output logic [rv_pipe_pkg::REG_ADDR_W-1:0] rs2_addr_o,
  input  logic [rv_pipe_pkg::XLEN-1:0]       rs1_data_i,
  input  logic [rv_pipe_pkg::XLEN-1:0]       rs2_data_i,
  output rv_pipe_pkg::id_ex_t                id_ex_o
);
  import rv_pipe_pkg::*;

  localparam int IDX_W = $clog2(REG_COUNT);

  logic [REG_ADDR_W-1:0] rd_addr;
  logic [XLEN-1:0]       imm_i;
  logic [XLEN-1:0]       imm_u;
  logic                  supported;
  id_ex_t                id_ex_d;

  // funct3 plus the funct7[5] modifier
  function automatic alu_op_e funct_to_op(input logic [2:0] funct3, input logic alt);
    alu_op_e op;
    case (funct3)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  // register indices beyond REG_COUNT wrap onto the low bits
  assign rs1_addr_o = REG_ADDR_W'(fetch_inst_i.r_fmt.rs1[IDX_W-1:0]);
  assign rs2_addr_o = REG_ADDR_W'(fetch_inst_i.r_fmt.rs2[IDX_W-1:0]);
  assign rd_addr    = REG_ADDR_W'(fetch_inst_i.u_fmt.rd[IDX_W-1:0]);

  // immediates
  assign imm_i = {{(XLEN-12){fetch_inst_i.i_fmt.imm12[11]}}, fetch_inst_i.i_fmt.imm12};
  assign imm_u = {fetch_inst_i.u_fmt.imm20, 12'b0};

  always_comb begin
    supported       = 1'b1;
    id_ex_d.rd      = rd_addr;
    id_ex_d.rs1_val = rs1_data_i;
    id_ex_d.op2_val = rs2_data_i;
    id_ex_d.alu_op  = ALU_ADD;
    case (fetch_inst_i.r_fmt.opcode)
      OP: begin
        id_ex_d.alu_op = funct_to_op(fetch_inst_i.r_fmt.funct3, fetch_inst_i.r_fmt.funct7[5]);
      end
      OP_IMM: begin
        // shifts take shamt, SRAI flagged by imm bit 10
        if (fetch_inst_i.i_fmt.funct3[1:0] == 2'b01) begin
          id_ex_d.op2_val = XLEN'(fetch_inst_i.i_fmt.imm12[4:0]);
          id_ex_d.alu_op  = funct_to_op(fetch_inst_i.i_fmt.funct3,
                                        fetch_inst_i.i_fmt.funct3[2] &
                                        fetch_inst_i.i_fmt.imm12[10]);
        end else begin
          id_ex_d.op2_val = imm_i;
          id_ex_d.alu_op  = funct_to_op(fetch_inst_i.i_fmt.funct3, 1'b0);
        end
      end
      LUI: begin
        id_ex_d.op2_val = imm_u;
        id_ex_d.alu_op  = ALU_PASS_B;
      end
      default: begin
        supported = 1'b0;
      end
    endcase
    // nothing to write back for x0 or unknown opcodes
    id_ex_d.valid = fetch_valid_i & supported & (rd_addr != '0);
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      id_ex_o.valid <= 1'b0;
    end else begin
      id_ex_o <= id_ex_d;
    end
  end

endmodule

// File: logic/fetch_handshake.sv
`timescale 1ns/1ps

module fetch_handshake (
  input  logic               clk,
  input  logic               rst_i,
  input  logic               inst_req_i,
  input  rv_pipe_pkg::inst_u inst_i,
  output logic               inst_ack_o,
  output logic               fetch_valid_o,
  output rv_pipe_pkg::inst_u fetch_inst_o
);

  logic accept;

  // new request seen while ack is still low
  assign accept = inst_req_i & ~inst_ack_o;

  // ==========================================================
  // four-phase ack
  // ==========================================================

  always_ff @(posedge clk) begin
    if (rst_i) begin
      inst_ack_o    <= 1'b0;
      fetch_valid_o <= 1'b0;
    end else begin
      fetch_valid_o <= accept;
      if (accept) begin
        inst_ack_o <= 1'b1;
      end else if (!inst_req_i) begin
        // source has released req, return to idle
        inst_ack_o <= 1'b0;
      end
    end
  end

  // fetch register, loads once per handshake
  always_ff @(posedge clk) begin
    if (accept) begin
      fetch_inst_o <= inst_i;
    end
  end

endmodule

// File: logic/rv_pipe_pkg.sv
package rv_pipe_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  // major opcodes the pipeline executes
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111
  } opcode_e;

  // ==========================================================
  // instruction word views
  // ==========================================================

  typedef struct packed {
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0]           imm12;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } i_type_t;

  typedef struct packed {
    logic [19:0]           imm20;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } u_type_t;

  // one word, three decodings
  typedef union packed {
    r_type_t r_fmt;
    i_type_t i_fmt;
    u_type_t u_fmt;
  } inst_u;

  // ==========================================================
  // ALU and stage payloads
  // ==========================================================

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  typedef struct packed {
    logic                  valid;
    logic [REG_ADDR_W-1:0] rd;
    alu_op_e               alu_op;
    logic [XLEN-1:0]       rs1_val;
    logic [XLEN-1:0]       op2_val;
  } id_ex_t;

  typedef struct packed {
    logic                  valid;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       data;
  } wb_t;

endpackage
